/* Makefile */
SRCS := $(filter-out +%,$(shell cat exec_pipeline.f)) src/exec_defs.svh
BIN  := obj_dir/Vexec_pipeline_tb

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -qx 'all tests passed' sim.log

$(BIN): $(SRCS) exec_pipeline.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module exec_pipeline_tb -f exec_pipeline.f -o Vexec_pipeline_tb

clean:
	rm -rf obj_dir sim.log

/* exec_pipeline.f */
+incdir+src
src/exec_pkg.sv
src/fu_if.sv
src/pipestage.sv
src/alu.sv
src/simd_unit.sv
src/eflags_reg.sv
src/execute_top.sv
src/exec_pipeline.sv
tb/exec_pipeline_checker.sv
tb/exec_pipeline_tb.sv

/* src/alu.sv */
/*
 * Scalar ALU
 * MOV, ADD, SUB, logic ops and CMP on the low word, sized by opsize
 */
`include "exec_defs.svh"

module alu (
    fu_if.unit fu
);
    import exec_pkg::*;

    word_t              mask;
    word_t              a_m;
    word_t              b_m;
    word_t              res_m;
    word_t              half_carry;
    logic [`WORD_W:0]   raw;
    logic               arith;
    logic               carry;
    logic               sa, sb, sr;
    flags_t             f;

    // Sign bit of a sized value
    function automatic logic top_bit(input word_t x, input opsize_t sz);
        case (sz)
            `SZ_8:   top_bit = x[7];
            `SZ_16:  top_bit = x[15];
            default: top_bit = x[31];
        endcase
    endfunction

    always_comb begin
        case (fu.opsize)
            `SZ_8:   mask = 32'h0000_00ff;
            `SZ_16:  mask = 32'h0000_ffff;
            default: mask = '1;
        endcase
        a_m = fu.a[`WORD_W-1:0] & mask;
        b_m = fu.b[`WORD_W-1:0] & mask;

        // One extra bit catches carry or borrow at 32 bits
        case (fu.op)
            `OP_ADD:          raw = {1'b0, a_m} + {1'b0, b_m};
            `OP_SUB, `OP_CMP: raw = {1'b0, a_m} - {1'b0, b_m};
            `OP_AND:          raw = {1'b0, a_m & b_m};
            `OP_OR:           raw = {1'b0, a_m | b_m};
            `OP_XOR:          raw = {1'b0, a_m ^ b_m};
            default:          raw = {1'b0, b_m};
        endcase
        res_m = raw[`WORD_W-1:0] & mask;
        arith = (fu.op == `OP_ADD) || (fu.op == `OP_SUB) || (fu.op == `OP_CMP);

        // Masked operands, so the bit just above the size is the carry
        case (fu.opsize)
            `SZ_8:   carry = raw[8];
            `SZ_16:  carry = raw[16];
            default: carry = raw[32];
        endcase

        sa = top_bit(a_m, fu.opsize);
        sb = top_bit(b_m, fu.opsize);
        sr = top_bit(res_m, fu.opsize);
        half_carry = a_m ^ b_m ^ raw[`WORD_W-1:0];

        f = '0;
        f[`FLAG_CF] = arith & carry;
        // Subtract overflows when operand signs differ
        if (fu.op == `OP_ADD) begin
            f[`FLAG_OF] = (sa == sb) && (sr != sa);
        end else if (arith) begin
            f[`FLAG_OF] = (sa != sb) && (sr != sa);
        end
        f[`FLAG_AF] = arith & half_carry[4];
        f[`FLAG_PF] = ~^res_m[7:0];
        f[`FLAG_ZF] = (res_m == '0);
        f[`FLAG_SF] = sr;
    end

    assign fu.result = {{(`DWORD_W-`WORD_W){1'b0}}, res_m};
    assign fu.flags  = f;

endmodule

/* src/eflags_reg.sv */
/*
 * Flags register
 * Architectural OF CF AF PF ZF SF, loaded by flag-setting ops
 */
module eflags_reg (
    input  logic            clk,
    input  logic            rst,
    input  logic            update,
    input  exec_pkg::flags_t flags_in,
    output exec_pkg::flags_t flags
);
    import exec_pkg::*;

    flags_t flags_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            flags_q <= '0;
        end else if (update) begin
            flags_q <= flags_in;
        end
    end

    assign flags = flags_q;

endmodule

/* src/exec_defs.svh */
/*
 * Execute stage definitions
 * Widths, opcode and opsize encodings, flag bit positions
 */
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Datapath widths
`define WORD_W  32
`define DWORD_W 64
`define FLAGS_W 6

// Opcodes, scalar group first
`define OP_MOV   4'd0
`define OP_ADD   4'd1
`define OP_SUB   4'd2
`define OP_AND   4'd3
`define OP_OR    4'd4
`define OP_XOR   4'd5
`define OP_CMP   4'd6
`define OP_CMOVC 4'd7
`define OP_XCHG  4'd8
// MMX packed adds
`define OP_PADDB 4'd9
`define OP_PADDW 4'd10
`define OP_PADDD 4'd11

// Operand size codes
`define SZ_8  2'd0
`define SZ_16 2'd1
`define SZ_32 2'd2

// Bit positions inside flags_t
`define FLAG_OF 0
`define FLAG_CF 1
`define FLAG_AF 2
`define FLAG_PF 3
`define FLAG_ZF 4
`define FLAG_SF 5

`endif

/* src/exec_pipeline.sv */
/*
 * Execute pipeline top
 * Register-read latch feeding the execute stage
 */
module exec_pipeline (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    // Request side
    input  logic              in_valid,
    output logic              in_ready,
    input  exec_pkg::dword_t  in_op_a,
    input  exec_pkg::dword_t  in_op_b,
    input  exec_pkg::opcode_t in_op,
    input  exec_pkg::opsize_t in_opsize,
    input  exec_pkg::reg_id_t in_dest_reg,
    input  exec_pkg::word_t   in_dest_address,
    input  logic              in_mem_or_reg,
    input  logic              in_branch_taken,
    input  logic              in_to_sys_controller,
    input  exec_pkg::word_t   in_pc,
    // Writeback side
    output logic              wb_valid,
    input  logic              wb_ready,
    output exec_pkg::dword_t  wb_result,
    output exec_pkg::flags_t  wb_flags,
    output exec_pkg::reg_id_t wb_dest_reg,
    output exec_pkg::word_t   wb_dest_address,
    output exec_pkg::opsize_t wb_opsize,
    output logic              wb_mem_or_reg,
    output logic              wb_branch_taken,
    output logic              wb_to_sys_controller,
    output exec_pkg::word_t   wb_pc
);
    import exec_pkg::*;

    localparam int RR_W = 2 * $bits(dword_t) + $bits(opcode_t) + $bits(opsize_t)
                        + $bits(reg_id_t) + 2 * $bits(word_t) + 3;

    // Latch to execute
    logic              e_valid;
    logic              e_ready;
    dword_t            e_op_a;
    dword_t            e_op_b;
    opcode_t           e_op;
    opsize_t           e_opsize;
    reg_id_t           e_dest_reg;
    word_t             e_dest_address;
    logic              e_mem_or_reg;
    logic              e_branch_taken;
    logic              e_to_sys_controller;
    word_t             e_pc;
    logic [RR_W-1:0]   rr_in;
    logic [RR_W-1:0]   rr_out;

    assign rr_in = {in_op_a, in_op_b, in_op, in_opsize, in_dest_reg, in_dest_address,
                    in_mem_or_reg, in_branch_taken, in_to_sys_controller, in_pc};

    assign {e_op_a, e_op_b, e_op, e_opsize, e_dest_reg, e_dest_address,
            e_mem_or_reg, e_branch_taken, e_to_sys_controller, e_pc} = rr_out;

    // Register-read latch, also emptied by flush
    pipestage #(.WIDTH(RR_W)) rr_stage (
        .clk      (clk),
        .rst      (rst | flush),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (rr_in),
        .out_valid(e_valid),
        .out_ready(e_ready),
        .out_data (rr_out)
    );

    execute_top execute_inst (
        .clk                 (clk),
        .rst                 (rst),
        .flush               (flush),
        .e_valid             (e_valid),
        .e_ready             (e_ready),
        .e_op_a              (e_op_a),
        .e_op_b              (e_op_b),
        .e_op                (e_op),
        .e_opsize            (e_opsize),
        .e_dest_reg          (e_dest_reg),
        .e_dest_address      (e_dest_address),
        .e_mem_or_reg        (e_mem_or_reg),
        .e_branch_taken      (e_branch_taken),
        .e_to_sys_controller (e_to_sys_controller),
        .e_pc                (e_pc),
        .wb_valid            (wb_valid),
        .wb_ready            (wb_ready),
        .wb_result           (wb_result),
        .wb_flags            (wb_flags),
        .wb_dest_reg         (wb_dest_reg),
        .wb_dest_address     (wb_dest_address),
        .wb_opsize           (wb_opsize),
        .wb_mem_or_reg       (wb_mem_or_reg),
        .wb_branch_taken     (wb_branch_taken),
        .wb_to_sys_controller(wb_to_sys_controller),
        .wb_pc               (wb_pc)
    );

endmodule

/* src/exec_pkg.sv */
/*
 * Execute stage package
 * Vector types shared by the datapath and the testbench
 */
`include "exec_defs.svh"

package exec_pkg;

    // Address or scalar value
    typedef logic [`WORD_W-1:0] word_t;

    // Full MMX-wide operand or result
    typedef logic [`DWORD_W-1:0] dword_t;

    // Operation select
    typedef logic [3:0] opcode_t;

    // 8, 16 or 32 bit operand size
    typedef logic [1:0] opsize_t;

    // OF CF AF PF ZF SF, see FLAG_* positions
    typedef logic [`FLAGS_W-1:0] flags_t;

    // Architectural register number
    typedef logic [2:0] reg_id_t;

endpackage

/* src/execute_top.sv */
/*
 * Execute stage
 * Runs ALU and SIMD in parallel, handles CMOVC and XCHG locally,
 * updates flags and registers the result toward writeback
 */
`include "exec_defs.svh"

module execute_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    // From register read
    input  logic              e_valid,
    output logic              e_ready,
    input  exec_pkg::dword_t  e_op_a,
    input  exec_pkg::dword_t  e_op_b,
    input  exec_pkg::opcode_t e_op,
    input  exec_pkg::opsize_t e_opsize,
    input  exec_pkg::reg_id_t e_dest_reg,
    input  exec_pkg::word_t   e_dest_address,
    input  logic              e_mem_or_reg,
    input  logic              e_branch_taken,
    input  logic              e_to_sys_controller,
    input  exec_pkg::word_t   e_pc,
    // To writeback
    output logic              wb_valid,
    input  logic              wb_ready,
    output exec_pkg::dword_t  wb_result,
    output exec_pkg::flags_t  wb_flags,
    output exec_pkg::reg_id_t wb_dest_reg,
    output exec_pkg::word_t   wb_dest_address,
    output exec_pkg::opsize_t wb_opsize,
    output logic              wb_mem_or_reg,
    output logic              wb_branch_taken,
    output logic              wb_to_sys_controller,
    output exec_pkg::word_t   wb_pc
);
    import exec_pkg::*;

    localparam int PIPE_W = $bits(dword_t) + $bits(flags_t) + $bits(reg_id_t)
                          + 2 * $bits(word_t) + $bits(opsize_t) + 3;

    fu_if alu_fu ();
    fu_if simd_fu ();

    flags_t           cur_flags;
    flags_t           new_flags;
    logic             flag_op;
    logic             update;
    dword_t           result;
    logic [PIPE_W-1:0] pipe_in;
    logic [PIPE_W-1:0] pipe_out;

    // Same operands fan out to both units
    assign alu_fu.a       = e_op_a;
    assign alu_fu.b       = e_op_b;
    assign alu_fu.op      = e_op;
    assign alu_fu.opsize  = e_opsize;
    assign simd_fu.a      = e_op_a;
    assign simd_fu.b      = e_op_b;
    assign simd_fu.op     = e_op;
    assign simd_fu.opsize = e_opsize;

    alu       alu_inst  (.fu(alu_fu));
    simd_unit simd_inst (.fu(simd_fu));

    // ADD through CMP set flags, MOV does not
    assign flag_op = (e_op >= `OP_ADD) && (e_op <= `OP_CMP);
    assign update  = e_valid && e_ready && flag_op;

    eflags_reg eflags_inst (
        .clk     (clk),
        .rst     (rst),
        .update  (update),
        .flags_in(alu_fu.flags),
        .flags   (cur_flags)
    );

    // Flags as seen after this op
    assign new_flags = flag_op ? alu_fu.flags : cur_flags;

    always_comb begin
        case (e_op)
            // CF from the register, already holds the previous op's update
            `OP_CMOVC: result = {32'b0, cur_flags[`FLAG_CF] ? e_op_b[31:0] : e_op_a[31:0]};
            `OP_XCHG:  result = {e_op_a[31:0], e_op_b[31:0]};
            `OP_PADDB, `OP_PADDW, `OP_PADDD: result = simd_fu.result;
            default:   result = alu_fu.result;
        endcase
    end

    assign pipe_in = {result, new_flags, e_dest_reg, e_dest_address, e_opsize,
                      e_mem_or_reg, e_branch_taken, e_to_sys_controller, e_pc};

    assign {wb_result, wb_flags, wb_dest_reg, wb_dest_address, wb_opsize,
            wb_mem_or_reg, wb_branch_taken, wb_to_sys_controller, wb_pc} = pipe_out;

    // Flush drops the registered result
    pipestage #(.WIDTH(PIPE_W)) out_stage (
        .clk      (clk),
        .rst      (rst | flush),
        .in_valid (e_valid),
        .in_ready (e_ready),
        .in_data  (pipe_in),
        .out_valid(wb_valid),
        .out_ready(wb_ready),
        .out_data (pipe_out)
    );

endmodule

/* src/fu_if.sv */
/*
 * Functional unit interface
 * Operands and op from the execute stage, result and flags back
 */
interface fu_if;
    import exec_pkg::*;

    // Stage to unit
    dword_t  a;
    dword_t  b;
    opcode_t op;
    opsize_t opsize;

    // Unit to stage
    dword_t  result;
    flags_t  flags;

    modport stage (
        output a, b, op, opsize,
        input  result, flags
    );

    modport unit (
        input  a, b, op, opsize,
        output result, flags
    );

endinterface

/* src/pipestage.sv */
/*
 * Pipeline register
 * One-entry valid/ready stage, holds its word while the output stalls
 */
module pipestage #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    // Free slot, or the current word leaves this edge
    assign in_ready = ~out_valid | out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves on an input transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

/* src/simd_unit.sv */
/*
 * Packed SIMD adder
 * Wrap-around add of 64-bit operands in byte, word or dword lanes
 */
`include "exec_defs.svh"

module simd_unit (
    fu_if.unit fu
);
    import exec_pkg::*;

    dword_t sum_b;
    dword_t sum_w;
    dword_t sum_d;

    // All three lane widths in parallel, op picks one
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            sum_b[i*8 +: 8] = fu.a[i*8 +: 8] + fu.b[i*8 +: 8];
        end
        for (int i = 0; i < 4; i++) begin
            sum_w[i*16 +: 16] = fu.a[i*16 +: 16] + fu.b[i*16 +: 16];
        end
        for (int i = 0; i < 2; i++) begin
            sum_d[i*32 +: 32] = fu.a[i*32 +: 32] + fu.b[i*32 +: 32];
        end
    end

    assign fu.result = (fu.op == `OP_PADDB) ? sum_b :
                       (fu.op == `OP_PADDW) ? sum_w : sum_d;

    // Packed adds leave flags alone
    assign fu.flags = '0;

endmodule

/* tb/exec_pipeline_checker.sv */
/*
 * Execute pipeline checker
 * Reference model and scoreboard for the writeback stream,
 * plus stall, back-pressure, reset and flush properties
 */
`include "exec_defs.svh"

module exec_pipeline_checker (
    input logic              clk,
    input logic              rst,
    input logic              flush,
    input logic              in_valid,
    input logic              in_ready,
    input exec_pkg::dword_t  in_op_a,
    input exec_pkg::dword_t  in_op_b,
    input exec_pkg::opcode_t in_op,
    input exec_pkg::opsize_t in_opsize,
    input exec_pkg::reg_id_t in_dest_reg,
    input exec_pkg::word_t   in_dest_address,
    input logic              in_mem_or_reg,
    input logic              in_branch_taken,
    input logic              in_to_sys_controller,
    input exec_pkg::word_t   in_pc,
    input logic              e_valid,
    input logic              wb_valid,
    input logic              wb_ready,
    input exec_pkg::dword_t  wb_result,
    input exec_pkg::flags_t  wb_flags,
    input exec_pkg::reg_id_t wb_dest_reg,
    input exec_pkg::word_t   wb_dest_address,
    input exec_pkg::opsize_t wb_opsize,
    input logic              wb_mem_or_reg,
    input logic              wb_branch_taken,
    input logic              wb_to_sys_controller,
    input exec_pkg::word_t   wb_pc
);
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    // Expected writeback item with the sideband ending in the pc
    typedef struct packed {
        dword_t      result;
        flags_t      flags;
        logic [71:0] side;
    } exp_t;

    exp_t        q[$];
    exp_t        head = '0;
    flags_t      model_flags = '0;
    logic        flags_known = 1'b1;
    int          pending = 0;
    int          checked_count = 0;
    int          err_count = 0;
    logic        in_fire;
    logic        wb_fire;
    logic [71:0] in_side;
    logic [71:0] wb_side;

    // Transfers on a flush or reset edge do not count
    assign in_fire = in_valid && in_ready && !rst && !flush;
    assign wb_fire = wb_valid && wb_ready && !rst && !flush;
    assign in_side = {in_dest_reg, in_dest_address, in_opsize, in_mem_or_reg,
                      in_branch_taken, in_to_sys_controller, in_pc};
    assign wb_side = {wb_dest_reg, wb_dest_address, wb_opsize, wb_mem_or_reg,
                      wb_branch_taken, wb_to_sys_controller, wb_pc};

    // One operation from the flags before it
    function automatic void run_op(input dword_t a, input dword_t b, input opcode_t op,
                                   input opsize_t sz, input flags_t fin,
                                   output dword_t res, output flags_t fout);
        longint unsigned lim;
        longint unsigned am;
        longint unsigned bm;
        longint unsigned r;
        longint          half;
        longint          sx;
        longint          sy;
        dword_t          h;
        int              n;
        logic            sr;
        n    = (sz == `SZ_8) ? 8 : (sz == `SZ_16) ? 16 : 32;
        lim  = (64'd1 << n) - 64'd1;
        am   = {32'b0, a[31:0]} & lim;
        bm   = {32'b0, b[31:0]} & lim;
        fout = fin;
        case (op)
            `OP_ADD:          r = am + bm;
            `OP_SUB, `OP_CMP: r = am - bm;
            `OP_AND:          r = am & bm;
            `OP_OR:           r = am | bm;
            `OP_XOR:          r = am ^ bm;
            default:          r = bm;
        endcase
        r   = r & lim;
        res = r;
        sr  = r[n-1];
        // Signed operand values at the operation size
        half = longint'(64'd1 << (n - 1));
        sx   = (am >= half) ? longint'(am) - 2 * half : longint'(am);
        sy   = (bm >= half) ? longint'(bm) - 2 * half : longint'(bm);
        if (op >= `OP_ADD && op <= `OP_CMP) begin
            fout = '0;
            if (op == `OP_ADD) begin
                fout[`FLAG_CF] = (am + bm) > lim;
                fout[`FLAG_AF] = ((am & 64'd15) + (bm & 64'd15)) > 64'd15;
                // Overflow when the true sum leaves the signed range
                fout[`FLAG_OF] = (sx + sy >= half) || (sx + sy < -half);
            end else if (op == `OP_SUB || op == `OP_CMP) begin
                // Borrow when the subtrahend is larger
                fout[`FLAG_CF] = am < bm;
                fout[`FLAG_AF] = (am & 64'd15) < (bm & 64'd15);
                fout[`FLAG_OF] = (sx - sy >= half) || (sx - sy < -half);
            end
            fout[`FLAG_ZF] = (r == 64'd0);
            fout[`FLAG_SF] = sr;
            fout[`FLAG_PF] = ($countones(r[7:0]) % 2) == 0;
        end
        case (op)
            `OP_CMOVC: res = {32'b0, fin[`FLAG_CF] ? b[31:0] : a[31:0]};
            `OP_XCHG:  res = {a[31:0], b[31:0]};
            `OP_PADDB, `OP_PADDW, `OP_PADDD: begin
                // Lane tops masked so no carry crosses a lane and patched back after
                h = (op == `OP_PADDB) ? 64'h8080_8080_8080_8080 :
                    (op == `OP_PADDW) ? 64'h8000_8000_8000_8000 : 64'h8000_0000_8000_0000;
                res = ((a & ~h) + (b & ~h)) ^ ((a ^ b) & h);
            end
            default: ;
        endcase
    endfunction

    // Scoreboard queue in program order
    always @(posedge clk) begin
        dword_t r;
        flags_t f;
        if (rst) begin
            q.delete();
            model_flags <= '0;
            flags_known <= 1'b1;
        end else if (flush) begin
            // In-flight work dropped and the flags register no longer tracked
            q.delete();
            flags_known <= 1'b0;
        end else begin
            if (wb_fire) begin
                if (q.size() != 0) begin
                    void'(q.pop_front());
                end
                checked_count <= checked_count + 1;
            end
            if (in_fire) begin
                run_op(in_op_a, in_op_b, in_op, in_opsize, model_flags, r, f);
                q.push_back({r, f, in_side});
                model_flags <= f;
                if (in_op >= `OP_ADD && in_op <= `OP_CMP) begin
                    flags_known <= 1'b1;
                end
            end
        end
        head    <= (q.size() != 0) ? q[0] : '0;
        pending <= q.size();
    end

    // Oldest model item against each writeback transfer
    assert property (@(posedge clk) wb_fire |-> pending != 0)
        else begin
            $error("Writeback transfer with no operation in flight");
            err_count++;
        end
    assert property (@(posedge clk) wb_fire && pending != 0 |-> wb_result == head.result)
        else begin
            $error("Fail wb_result exp %h got %h", $sampled(head.result), $sampled(wb_result));
            err_count++;
        end
    assert property (@(posedge clk) wb_fire && pending != 0 |-> wb_flags == head.flags)
        else begin
            $error("Fail wb_flags exp %h got %h", $sampled(head.flags), $sampled(wb_flags));
            err_count++;
        end
    assert property (@(posedge clk) wb_fire && pending != 0 |-> wb_side == head.side)
        else begin
            $error("Fail wb_dest_reg..wb_pc exp %h got %h",
                   $sampled(head.side), $sampled(wb_side));
            err_count++;
        end

    // Stalled writeback holds its item
    assert property (@(posedge clk) wb_valid && !wb_ready && !rst && !flush |=>
                     wb_valid && $stable(wb_result) && $stable(wb_flags) && $stable(wb_side))
        else begin
            $error("Writeback outputs changed while stalled");
            err_count++;
        end

    // Input stalls only with both stages full and writeback stalled
    assert property (@(posedge clk) !rst && !in_ready |-> e_valid && wb_valid && !wb_ready)
        else begin
            $error("in_ready low while the pipeline could accept");
            err_count++;
        end

    assert property (@(posedge clk) rst || flush |=> !wb_valid && in_ready)
        else begin
            $error("Pipeline not empty after reset or flush");
            err_count++;
        end

    // Model resyncs only through a flag-setting op
    assert property (@(posedge clk) in_fire && !flags_known |->
                     in_op >= `OP_ADD && in_op <= `OP_CMP)
        else begin
            $error("First operation after flush does not set flags");
            err_count++;
        end

endmodule

/* tb/exec_pipeline_tb.sv */
/*
 * Execute pipeline testbench
 * Random operations with back-pressure and flushes,
 * results checked by the bound checker
 */
`include "exec_defs.svh"

module exec_pipeline_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    localparam int NUM_OPS = 2000;
    // About ten cycles per operation covers stalls and flushes
    localparam int MAX_CYCLES = 10 * NUM_OPS;

    logic    clk = 1'b0;
    logic    rst;
    logic    flush;
    logic    in_valid;
    logic    in_ready;
    dword_t  in_op_a;
    dword_t  in_op_b;
    opcode_t in_op;
    opsize_t in_opsize;
    reg_id_t in_dest_reg;
    word_t   in_dest_address;
    logic    in_mem_or_reg;
    logic    in_branch_taken;
    logic    in_to_sys_controller;
    word_t   in_pc;
    logic    wb_valid;
    logic    wb_ready;
    dword_t  wb_result;
    flags_t  wb_flags;
    reg_id_t wb_dest_reg;
    word_t   wb_dest_address;
    opsize_t wb_opsize;
    logic    wb_mem_or_reg;
    logic    wb_branch_taken;
    logic    wb_to_sys_controller;
    word_t   wb_pc;
    int      cycles = 0;
    int      issued = 0;
    int      errors;
    logic    need_flag_op;

    always #2 clk = ~clk;

    exec_pipeline exec_pipeline_inst (.*);

    bind exec_pipeline exec_pipeline_checker checker_inst (.*);

    // Present a new random request, optionally restricted to flag setters
    task automatic new_request(input logic flag_only);
        dword_t a;
        a = {$urandom, $urandom};
        in_valid <= 1'b1;
        in_op    <= flag_only ? opcode_t'($urandom_range(`OP_ADD, `OP_CMP))
                              : opcode_t'($urandom_range(`OP_MOV, `OP_PADDD));
        in_op_a  <= a;
        // Equal operands now and then for zero results
        in_op_b  <= ($urandom_range(0, 7) == 0) ? a : {$urandom, $urandom};
        in_opsize       <= opsize_t'($urandom_range(0, 2));
        in_dest_reg     <= reg_id_t'($urandom_range(0, 7));
        in_dest_address <= $urandom;
        in_mem_or_reg   <= 1'($urandom_range(0, 1));
        in_branch_taken <= 1'($urandom_range(0, 1));
        in_to_sys_controller <= 1'($urandom_range(0, 1));
        in_pc           <= $urandom;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d operations issued", cycles, issued);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        logic fire;
        void'($urandom(32'hb1aa_4358));
        rst = 1'b1;
        flush = 1'b0;
        in_valid = 1'b0;
        in_op_a = '0;
        in_op_b = '0;
        in_op = '0;
        in_opsize = '0;
        in_dest_reg = '0;
        in_dest_address = '0;
        in_mem_or_reg = 1'b0;
        in_branch_taken = 1'b0;
        in_to_sys_controller = 1'b0;
        in_pc = '0;
        wb_ready = 1'b0;
        need_flag_op = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        wb_ready <= 1'b1;
        new_request(1'b0);
        while (issued < NUM_OPS) begin
            // Handshake settles mid-cycle
            @(negedge clk);
            fire = in_valid && in_ready && !flush;
            @(posedge clk);
            flush    <= 1'b0;
            wb_ready <= ($urandom_range(0, 3) != 0);
            if (fire) begin
                issued++;
                need_flag_op = 1'b0;
            end
            if ($urandom_range(0, 199) == 0) begin
                // Request withdrawn under flush
                flush        <= 1'b1;
                in_valid     <= 1'b0;
                need_flag_op = 1'b1;
            end else if (fire || !in_valid) begin
                new_request(need_flag_op);
            end
        end
        in_valid <= 1'b0;
        flush    <= 1'b0;
        wb_ready <= 1'b1;
        // Drain everything still in flight
        @(negedge clk);
        while (exec_pipeline_inst.checker_inst.pending != 0 || wb_valid) begin
            @(negedge clk);
        end
        errors = exec_pipeline_inst.checker_inst.err_count;
        $display("Checked %0d results, %0d errors",
                 exec_pipeline_inst.checker_inst.checked_count, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
